/* rtl/rom_loader_pkg.sv */
// ROM loader widths, slot and selection codes, pad byte, reset hold count, index union
package rom_loader_pkg;

	// ==============================
	// Address widths
	// ==============================
	localparam int ROM_ADDR_W   = 15;
	localparam int OS_ADDR_W    = 14;
	localparam int BASIC_ADDR_W = 13;
	localparam int DL_ADDR_W    = 14;

	// Aligned OS images end on this address
	localparam logic [OS_ADDR_W-1:0] OS_LAST_ADDR = 14'h3FFF;

	// Returned for unmapped or unloaded regions
	localparam logic [7:0] PAD_BYTE = 8'hFF;

	// ==============================
	// Download index codes
	// ==============================
	// Slot numbers, compared with the low six index bits
	localparam logic [5:0] SLOT_XL    = 6'd4;
	localparam logic [5:0] SLOT_BASIC = 6'd5;
	localparam logic [5:0] SLOT_OSA   = 6'd6;
	localparam logic [5:0] SLOT_OSB   = 6'd7;

	// Raw index bytes of the boot image files
	localparam logic [7:0] BOOT_XL    = 8'h00;
	localparam logic [7:0] BOOT_BASIC = 8'h40;
	localparam logic [7:0] BOOT_OSA   = 8'h80;
	localparam logic [7:0] BOOT_OSB   = 8'hC0;

	// ==============================
	// Machine selection
	// ==============================
	// Bit 1 marks an 800 machine, bit 0 picks OS-B over OS-A
	localparam logic [1:0] SEL_XL_BASIC = 2'd0;
	localparam logic [1:0] SEL_XL       = 2'd1;
	localparam logic [1:0] SEL_800_OSA  = 2'd2;
	localparam logic [1:0] SEL_800_OSB  = 2'd3;

	// Cold reset request length in clk_sys cycles
	localparam int LOAD_RESET_HOLD = 1000;
	localparam int HOLD_CNT_W      = $clog2(LOAD_RESET_HOLD + 1);

	// Download index byte, raw or as file type over slot number
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] ftype;
			logic [5:0] slot;
		} sel;
	} load_index_u;

endpackage

/* rtl/rom_image.sv */
// Byte-wide dual-port ROM image memory with optional top alignment and padding
`timescale 1ns/1ps

module rom_image #(
	parameter int ADDR_W    = rom_loader_pkg::OS_ADDR_W,
	parameter bit ALIGN_TOP = 1'b1
) (
	input  logic              clk_sys,
	input  logic              areset,
	input  logic              wr_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  logic [7:0]        wr_data_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	output logic [7:0]        rd_data_o
);
	import rom_loader_pkg::*;

	logic [7:0]        mem [0:2**ADDR_W-1];
	logic [7:0]        mem_q;
	logic              pad_q;
	logic [ADDR_W-1:0] rd_index;
	logic              pad_next;

	// ==============================
	// Alignment
	// ==============================
	if (ALIGN_TOP) begin : g_align
		logic [ADDR_W-1:0] offset_q;

		// The last written byte lands on the top address
		always_ff @(posedge clk_sys) begin
			if (wr_i) begin
				offset_q <= ADDR_W'(OS_LAST_ADDR) - wr_addr_i;
			end
		end

		assign rd_index = rd_addr_i - offset_q;
		assign pad_next = (rd_addr_i < offset_q);
	end else begin : g_plain
		assign rd_index = rd_addr_i;
		assign pad_next = 1'b0;
	end

	// Download side
	always_ff @(posedge clk_sys) begin
		if (wr_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// CPU side registers the byte and the pad decision together
	always_ff @(posedge clk_sys) begin
		mem_q <= mem[rd_index];
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			pad_q <= 1'b1;
		end else begin
			pad_q <= pad_next;
		end
	end

	assign rd_data_o = pad_q ? PAD_BYTE : mem_q;

endmodule

/* rtl/rom_store_array.sv */
// Download index decode and the four system ROM image memories
`timescale 1ns/1ps

module rom_store_array (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	input  logic                                 dl_wr_i,
	input  logic [rom_loader_pkg::DL_ADDR_W-1:0] dl_addr_i,
	input  logic [7:0]                           dl_data_i,
	input  rom_loader_pkg::load_index_u          dl_index_i,
	input  logic                                 boot_rom_off_i,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_addr_i,
	output logic [7:0]                           xl_data_o,
	output logic [7:0]                           basic_data_o,
	output logic [7:0]                           osa_data_o,
	output logic [7:0]                           osb_data_o
);
	import rom_loader_pkg::*;

	logic boot_ok;
	logic xl_wr;
	logic basic_wr;
	logic osa_wr;
	logic osb_wr;

	// ==============================
	// Index decode
	// ==============================
	// Boot image bytes count only while boot images are enabled
	assign boot_ok = ~boot_rom_off_i;

	assign xl_wr = dl_wr_i && ((dl_index_i.sel.slot == SLOT_XL) ||
		(boot_ok && dl_index_i.raw == BOOT_XL));
	assign basic_wr = dl_wr_i && ((dl_index_i.sel.slot == SLOT_BASIC) ||
		(boot_ok && dl_index_i.raw == BOOT_BASIC));
	assign osa_wr = dl_wr_i && ((dl_index_i.sel.slot == SLOT_OSA) ||
		(boot_ok && dl_index_i.raw == BOOT_OSA));
	assign osb_wr = dl_wr_i && ((dl_index_i.sel.slot == SLOT_OSB) ||
		(boot_ok && dl_index_i.raw == BOOT_OSB));

	// ==============================
	// Images
	// ==============================
	rom_image #(
		.ADDR_W    (OS_ADDR_W),
		.ALIGN_TOP (1'b1)
	) xl_image_inst (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_i      (xl_wr),
		.wr_addr_i (dl_addr_i[OS_ADDR_W-1:0]),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[OS_ADDR_W-1:0]),
		.rd_data_o (xl_data_o)
	);

	// BASIC is always a full 8K image
	rom_image #(
		.ADDR_W    (BASIC_ADDR_W),
		.ALIGN_TOP (1'b0)
	) basic_image_inst (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_i      (basic_wr),
		.wr_addr_i (dl_addr_i[BASIC_ADDR_W-1:0]),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[BASIC_ADDR_W-1:0]),
		.rd_data_o (basic_data_o)
	);

	rom_image #(
		.ADDR_W    (OS_ADDR_W),
		.ALIGN_TOP (1'b1)
	) osa_image_inst (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_i      (osa_wr),
		.wr_addr_i (dl_addr_i[OS_ADDR_W-1:0]),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[OS_ADDR_W-1:0]),
		.rd_data_o (osa_data_o)
	);

	rom_image #(
		.ADDR_W    (OS_ADDR_W),
		.ALIGN_TOP (1'b1)
	) osb_image_inst (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_i      (osb_wr),
		.wr_addr_i (dl_addr_i[OS_ADDR_W-1:0]),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[OS_ADDR_W-1:0]),
		.rd_data_o (osb_data_o)
	);

endmodule

/* rtl/machine_config.sv */
// Machine selection latch and cold reset request after a system ROM download
`timescale 1ns/1ps

module machine_config (
	input  logic                        clk_sys,
	input  logic                        areset,
	input  logic [1:0]                  machine_sel_i,
	input  logic [2:0]                  ram_xl_i,
	input  logic [2:0]                  ram_800_i,
	input  logic                        dl_active_i,
	input  rom_loader_pkg::load_index_u dl_index_i,
	output logic [1:0]                  rom_sel_o,
	output logic                        mode800_o,
	output logic [2:0]                  ram_config_o,
	output logic                        load_reset_o
);
	import rom_loader_pkg::*;

	logic [5:0]            slot;
	logic                  sys_slot;
	logic                  dl_sys_q;
	logic                  dl_end;
	logic                  dl_end_q;
	logic                  reset_req;
	logic                  reset_req_q;
	logic                  any_800;
	logic [HOLD_CNT_W-1:0] hold_cnt_q;

	// ==============================
	// Configuration latch
	// ==============================
	// Only follows the menu while the machine is held in reset
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			rom_sel_o    <= machine_sel_i;
			mode800_o    <= machine_sel_i[1];
			ram_config_o <= machine_sel_i[1] ? ram_800_i : ram_xl_i;
		end
	end

	// ==============================
	// Reset requirement
	// ==============================
	assign slot     = dl_index_i.sel.slot;
	assign sys_slot = (slot[5:2] == SLOT_XL[5:2]);
	assign any_800  = machine_sel_i[1] | rom_sel_o[1];

	// A reload needs a reset when the live or the latched machine uses that ROM
	always_comb begin
		reset_req = 1'b0;
		if (slot == SLOT_XL) begin
			reset_req = ~machine_sel_i[1] | ~rom_sel_o[1];
		end else if (slot == SLOT_BASIC) begin
			reset_req = (machine_sel_i == SEL_XL_BASIC) | (rom_sel_o == SEL_XL_BASIC);
		end else if (slot == SLOT_OSA) begin
			reset_req = any_800 & (~machine_sel_i[0] | ~rom_sel_o[0]);
		end else if (slot == SLOT_OSB) begin
			reset_req = any_800 & (machine_sel_i[0] | rom_sel_o[0]);
		end
	end

	// Falling edge of a system ROM download
	assign dl_end = dl_sys_q & ~dl_active_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			dl_sys_q    <= 1'b0;
			dl_end_q    <= 1'b0;
			reset_req_q <= 1'b0;
		end else begin
			dl_sys_q <= dl_active_i & sys_slot;
			dl_end_q <= dl_end;
			if (dl_active_i) begin
				reset_req_q <= reset_req;
			end
		end
	end

	// ==============================
	// Request pulse
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			load_reset_o <= 1'b0;
			hold_cnt_q   <= HOLD_CNT_W'(LOAD_RESET_HOLD);
		end else if (dl_end_q) begin
			load_reset_o <= reset_req_q;
			hold_cnt_q   <= '0;
		end else if (hold_cnt_q < HOLD_CNT_W'(LOAD_RESET_HOLD)) begin
			hold_cnt_q <= hold_cnt_q + 1'b1;
		end else begin
			load_reset_o <= 1'b0;
		end
	end

endmodule

/* rtl/rom_read_mux.sv */
// CPU ROM read selector over the four images by latched machine selection
`timescale 1ns/1ps

module rom_read_mux (
	input  logic                                  clk_sys,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_addr_i,
	input  logic [1:0]                            rom_sel_i,
	input  logic [7:0]                            xl_data_i,
	input  logic [7:0]                            basic_data_i,
	input  logic [7:0]                            osa_data_i,
	input  logic [7:0]                            osb_data_i,
	output logic [7:0]                            rom_data_o
);
	import rom_loader_pkg::*;

	logic [1:0] addr_hi_q;

	// Keeps the region bits in step with the image read latency
	always_ff @(posedge clk_sys) begin
		addr_hi_q <= rom_addr_i[ROM_ADDR_W-1:ROM_ADDR_W-2];
	end

	// ==============================
	// Region select
	// ==============================
	// 0000-1FFF BASIC on XL+Basic, 4000-7FFF OS, the rest unmapped
	always_comb begin
		if (addr_hi_q == 2'b00 && rom_sel_i == SEL_XL_BASIC) begin
			rom_data_o = basic_data_i;
		end else if (addr_hi_q[1] && !rom_sel_i[1]) begin
			rom_data_o = xl_data_i;
		end else if (addr_hi_q[1]) begin
			rom_data_o = rom_sel_i[0] ? osb_data_i : osa_data_i;
		end else begin
			rom_data_o = PAD_BYTE;
		end
	end

endmodule

/* rtl/rom_loader_top.sv */
// System ROM loader top with image store, machine configuration and read selector
`timescale 1ns/1ps

module rom_loader_top (
	input  logic                                  clk_sys,
	input  logic                                  areset,
	input  logic                                  dl_active_i,
	input  logic                                  dl_wr_i,
	input  logic [rom_loader_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [7:0]                            dl_data_i,
	input  rom_loader_pkg::load_index_u           dl_index_i,
	input  logic                                  boot_rom_off_i,
	input  logic [1:0]                            machine_sel_i,
	input  logic [2:0]                            ram_xl_i,
	input  logic [2:0]                            ram_800_i,
	input  logic [rom_loader_pkg::ROM_ADDR_W-1:0] rom_addr_i,
	output logic [7:0]                            rom_data_o,
	output logic                                  mode800_o,
	output logic [2:0]                            ram_config_o,
	output logic                                  load_reset_o
);

	logic [7:0] xl_data;
	logic [7:0] basic_data;
	logic [7:0] osa_data;
	logic [7:0] osb_data;
	logic [1:0] rom_sel;

	rom_store_array rom_store_array_inst (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.dl_index_i     (dl_index_i),
		.boot_rom_off_i (boot_rom_off_i),
		.rom_addr_i     (rom_addr_i),
		.xl_data_o      (xl_data),
		.basic_data_o   (basic_data),
		.osa_data_o     (osa_data),
		.osb_data_o     (osb_data)
	);

	machine_config machine_config_inst (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.machine_sel_i (machine_sel_i),
		.ram_xl_i      (ram_xl_i),
		.ram_800_i     (ram_800_i),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.rom_sel_o     (rom_sel),
		.mode800_o     (mode800_o),
		.ram_config_o  (ram_config_o),
		.load_reset_o  (load_reset_o)
	);

	rom_read_mux rom_read_mux_inst (
		.clk_sys      (clk_sys),
		.rom_addr_i   (rom_addr_i),
		.rom_sel_i    (rom_sel),
		.xl_data_i    (xl_data),
		.basic_data_i (basic_data),
		.osa_data_i   (osa_data),
		.osb_data_i   (osb_data),
		.rom_data_o   (rom_data_o)
	);

endmodule

/* sim/rom_loader_tb.sv */
// Testbench for the ROM loader top with a reference model and random read checks
`timescale 1ns/1ps

module rom_loader_tb;
	import rom_loader_pkg::*;

	logic                  clk_sys;
	logic                  areset;
	logic                  dl_active_i;
	logic                  dl_wr_i;
	logic [DL_ADDR_W-1:0]  dl_addr_i;
	logic [7:0]            dl_data_i;
	load_index_u           dl_index_i;
	logic                  boot_rom_off_i;
	logic [1:0]            machine_sel_i;
	logic [2:0]            ram_xl_i;
	logic [2:0]            ram_800_i;
	logic [ROM_ADDR_W-1:0] rom_addr_i;
	logic [7:0]            rom_data_o;
	logic                  mode800_o;
	logic [2:0]            ram_config_o;
	logic                  load_reset_o;

	// Model images 0 XL, 1 BASIC, 2 OS-A, 3 OS-B
	logic [7:0] img_mem [0:3][0:16383];
	int         img_last [0:3];
	logic [1:0] sel_model;
	logic       mode_model;
	logic [2:0] ram_model;
	integer     seed;

	rom_loader_top rom_loader_top_inst (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.dl_active_i    (dl_active_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.dl_index_i     (dl_index_i),
		.boot_rom_off_i (boot_rom_off_i),
		.machine_sel_i  (machine_sel_i),
		.ram_xl_i       (ram_xl_i),
		.ram_800_i      (ram_800_i),
		.rom_addr_i     (rom_addr_i),
		.rom_data_o     (rom_data_o),
		.mode800_o      (mode800_o),
		.ram_config_o   (ram_config_o),
		.load_reset_o   (load_reset_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ==============================
	// Reference model
	// ==============================
	// Slot number in the low six bits, or the boot byte while boot images count
	function automatic bit image_written(int id, logic [7:0] idx, logic boot_off);
		return (idx[5:0] == 6'(id + 4)) || (!boot_off && idx == 8'(id * 64));
	endfunction

	// The last loaded byte of a right-aligned OS image sits on 3FFF
	function automatic logic [7:0] os_byte(int id, logic [13:0] a);
		int offset;
		offset = 16383 - img_last[id];
		if (int'(a) < offset) begin
			return PAD_BYTE;
		end
		return img_mem[id][int'(a) - offset];
	endfunction

	function automatic logic [7:0] expected_byte(logic [14:0] a);
		if (a[14:13] == 2'b00 && sel_model == SEL_XL_BASIC) begin
			return img_mem[1][a[12:0]];
		end else if (a[14] && !sel_model[1]) begin
			return os_byte(0, a[13:0]);
		end else if (a[14]) begin
			return os_byte(sel_model[0] ? 3 : 2, a[13:0]);
		end
		return PAD_BYTE;
	endfunction

	// ==============================
	// Checks
	// ==============================
	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns: %s got %0h expected %0h", $time, what, actual, expected);
			$display("sim failed");
			$fatal(1, "Mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		$display("sim failed");
		$fatal(1, "Timeout");
	endtask

	// One cycle read latency
	task automatic read_check(input logic [14:0] a, input logic [7:0] expected, input string what);
		rom_addr_i = a;
		@(posedge clk_sys);
		#1;
		check_equal(rom_data_o, expected, what);
	endtask

	task automatic random_reads(input int n);
		int i;
		logic [14:0] a;
		for (i = 0; i < n; i++) begin
			a = 15'($random(seed));
			read_check(a, expected_byte(a), "random read");
		end
	endtask

	task automatic check_alignment(input int id);
		int offset;
		logic [14:0] a;
		offset = 16383 - img_last[id];
		a = {1'b1, 14'(offset)};
		read_check(a, img_mem[id][0], "first loaded byte");
		if (offset > 0) begin
			read_check(a - 15'd1, PAD_BYTE, "byte below the image");
		end
	endtask

	task automatic check_config();
		check_equal(mode800_o, mode_model, "mode800_o");
		check_equal(ram_config_o, ram_model, "ram_config_o");
	endtask

	// ==============================
	// Stimulus
	// ==============================
	task automatic apply_reset(input logic [1:0] sel, input logic [2:0] rxl, input logic [2:0] r800);
		machine_sel_i = sel;
		ram_xl_i = rxl;
		ram_800_i = r800;
		areset = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		areset = 1'b0;
		sel_model = sel;
		mode_model = sel[1];
		ram_model = sel[1] ? r800 : rxl;
		check_config();
	endtask

	// One byte per cycle from address 0
	task automatic run_download(input logic [7:0] idx, input int len);
		int a;
		int id;
		logic [7:0] d;
		dl_index_i.raw = idx;
		dl_active_i = 1'b1;
		for (a = 0; a < len; a++) begin
			d = 8'($random(seed));
			dl_wr_i = 1'b1;
			dl_addr_i = DL_ADDR_W'(a);
			dl_data_i = d;
			for (id = 0; id < 4; id++) begin
				if (image_written(id, idx, boot_rom_off_i)) begin
					img_mem[id][(id == 1) ? a % 8192 : a] = d;
					img_last[id] = a;
				end
			end
			@(posedge clk_sys);
			#1;
		end
		dl_wr_i = 1'b0;
		dl_active_i = 1'b0;
	endtask

	task automatic check_reset_pulse();
		int n;
		n = 0;
		while (!load_reset_o) begin
			@(posedge clk_sys);
			#1;
			n++;
			if (n > 20) begin
				timeout_fail("load_reset_o pulse never came");
			end
		end
		check_equal(n, 2, "load_reset_o rise delay");
		n = 0;
		while (load_reset_o) begin
			@(posedge clk_sys);
			#1;
			n++;
			if (n > LOAD_RESET_HOLD + 20) begin
				timeout_fail("load_reset_o pulse never ended");
			end
		end
		check_equal(n, LOAD_RESET_HOLD + 1, "load_reset_o length");
	endtask

	task automatic check_no_reset();
		int i;
		for (i = 0; i < 20; i++) begin
			@(posedge clk_sys);
			#1;
			check_equal(load_reset_o, 1'b0, "load_reset_o for an unused slot");
		end
	endtask

	initial begin
		seed = 32'h161;
		areset = 1'b1;
		dl_active_i = 1'b0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		dl_index_i.raw = 8'h00;
		boot_rom_off_i = 1'b1;
		machine_sel_i = SEL_XL_BASIC;
		ram_xl_i = '0;
		ram_800_i = '0;
		rom_addr_i = '0;

		// XL+Basic with a full BASIC and a short XL
		apply_reset(SEL_XL_BASIC, 3'($random(seed)), 3'($random(seed)));
		run_download({2'b00, SLOT_BASIC}, 8192);
		run_download({2'b00, SLOT_XL}, 256 + ({$random(seed)} % 8000));
		random_reads(400);
		check_alignment(0);

		// 800 machines with OS-A and OS-B
		apply_reset(SEL_800_OSA, 3'($random(seed)), 3'($random(seed)));
		run_download({2'b00, SLOT_OSA}, 256 + ({$random(seed)} % 12000));
		random_reads(300);
		check_alignment(2);
		run_download({2'b00, SLOT_OSB}, 256 + ({$random(seed)} % 12000));
		apply_reset(SEL_800_OSB, 3'($random(seed)), 3'($random(seed)));
		random_reads(300);
		check_alignment(3);

		// Menu changes hold until the next reset
		machine_sel_i = SEL_XL_BASIC;
		ram_xl_i = ~ram_model;
		ram_800_i = ram_model + 3'd1;
		random_reads(200);
		check_config();
		apply_reset(machine_sel_i, ram_xl_i, ram_800_i);
		random_reads(200);
		apply_reset(SEL_XL, 3'($random(seed)), 3'($random(seed)));
		random_reads(200);

		// Cold reset request
		run_download({2'b00, SLOT_XL}, 256 + ({$random(seed)} % 4000));
		check_reset_pulse();
		run_download({2'b00, SLOT_OSA}, 256 + ({$random(seed)} % 4000));
		check_no_reset();

		// Boot image index byte
		apply_reset(SEL_800_OSA, 3'($random(seed)), 3'($random(seed)));
		boot_rom_off_i = 1'b0;
		run_download(BOOT_OSA, 256 + ({$random(seed)} % 4000));
		random_reads(200);
		check_alignment(2);
		boot_rom_off_i = 1'b1;
		run_download(BOOT_OSA, 256 + ({$random(seed)} % 4000));
		random_reads(200);
		check_alignment(2);

		$display("sim passed");
		$finish;
	end

endmodule

/* rom_loader.f */
rtl/rom_loader_pkg.sv
rtl/rom_image.sv
rtl/rom_store_array.sv
rtl/machine_config.sv
rtl/rom_read_mux.sv
rtl/rom_loader_top.sv
sim/rom_loader_tb.sv

/* Bender.yml */
package:
  name: rom_loader

sources:
  - rtl/rom_loader_pkg.sv
  - rtl/rom_image.sv
  - rtl/rom_store_array.sv
  - rtl/machine_config.sv
  - rtl/rom_read_mux.sv
  - rtl/rom_loader_top.sv
  - target: simulation
    files:
      - sim/rom_loader_tb.sv
